// File: axi_fifo_rd.f
verilog/axi_rd_pkg.sv
verilog/axi_ar_if.sv
verilog/axi_r_if.sv
verilog/ar_space_gate.sv
verilog/r_data_fifo.sv
verilog/axi_fifo_rd.sv
tb/tb_clk_gen.sv
tb/axi_rd_slave_model.sv
tb/tb_axi_fifo_rd.sv

// File: Makefile
# Verilator build and run for the AXI read-path buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_fifo_rd
FILELIST  ?= axi_fifo_rd.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Result comes from the log, not from the simulator exit code
run: compile
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_axi_fifo_rd.sv
//********************
// Testbench for the AXI read-path buffer
// Random bursts through a behavioral slave, scoreboard on
// the upstream R channel, space and back-pressure checks
//********************

`timescale 1ns/1ps

module tb_axi_fifo_rd
    import axi_rd_pkg::*;
();

    localparam int          DEPTH       = 16;
    localparam logic [31:0] SEED        = 32'he0b3;
    localparam int          N_BURSTS    = 40;
    // Upper bound on beats, every burst at most 16 plus the oversize one
    localparam int          MAX_BEATS   = N_BURSTS * 16 + 24;
    localparam int          WDOG_CYCLES = MAX_BEATS * 20 + 1000;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } beat_t;

    logic  clk;
    logic  rst;
    id_t   s_arid;
    addr_t s_araddr;
    len_t  s_arlen;
    logic  s_arvalid;
    logic  s_arready;
    id_t   s_rid;
    data_t s_rdata;
    resp_t s_rresp;
    logic  s_rlast;
    logic  s_rvalid;
    logic  s_rready;
    id_t   m_arid;
    addr_t m_araddr;
    len_t  m_arlen;
    logic  m_arvalid;
    logic  m_arready;
    id_t   m_rid;
    data_t m_rdata;
    resp_t m_rresp;
    logic  m_rlast;
    logic  m_rvalid;
    logic  m_rready;

    // Scoreboard of accepted upstream ARs
    id_t         sb_id[$];
    addr_t       sb_addr[$];
    len_t        sb_len[$];
    int unsigned sb_beat;
    int unsigned beats_seen;
    int          reserved;
    int          errors;
    beat_t       exp_beat;
    logic [31:0] stim_rng;
    logic [31:0] ready_rng;
    logic        throttle;
    logic        space_check;
    string       test_name;

    tb_clk_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(8)) i_clk_gen (.clk(clk), .rst(rst));

    axi_fifo_rd #(.FIFO_DEPTH(DEPTH)) i_axi_fifo_rd (.*);

    axi_rd_slave_model #(.SEED(SEED ^ 32'h0000_5a5a)) i_slave (
        .clk     (clk),
        .rst     (rst),
        .arid    (m_arid),
        .araddr  (m_araddr),
        .arlen   (m_arlen),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .rid     (m_rid),
        .rdata   (m_rdata),
        .rresp   (m_rresp),
        .rlast   (m_rlast),
        .rvalid  (m_rvalid),
        .rready  (m_rready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Beat k of a burst: data A + 4k, SLVERR when address bit 12 is set
    function automatic beat_t expected_beat(input id_t id, input addr_t addr, input len_t len,
                                            input int unsigned k);
        beat_t b;
        b.id   = id;
        b.data = addr + data_t'(4 * k);
        b.resp = addr[12] ? RESP_SLVERR : RESP_OKAY;
        b.last = (k == 32'(len));
        return b;
    endfunction

    task automatic check_data(input data_t exp, input data_t got);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: rdata expected %h, got %h", test_name, exp, got);
        end
    endtask

    task automatic check_id(input id_t exp, input id_t got);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: rid expected %h, got %h", test_name, exp, got);
        end
    endtask

    task automatic check_resp(input resp_t exp_resp, input logic exp_last,
                              input resp_t got_resp, input logic got_last);
        if (got_resp !== exp_resp || got_last !== exp_last) begin
            errors++;
            $display("[ERROR] %s: rresp/rlast expected %b/%b, got %b/%b",
                     test_name, exp_resp, exp_last, got_resp, got_last);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected %b, got %b", test_name, what, exp, got);
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the handshake edge
    task automatic issue_burst(input id_t id, input addr_t addr, input len_t len);
        s_arid    = id;
        s_araddr  = addr;
        s_arlen   = len;
        s_arvalid = 1'b1;
        @(posedge clk);
        while (!s_arready) @(posedge clk);
        #1;
        s_arvalid = 1'b0;
    endtask

    task automatic wait_drain();
        while (sb_len.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_random_bursts(input string name, input int count, input int max_beats);
        test_name = name;
        for (int i = 0; i < count; i++) begin
            stim_rng = xorshift(stim_rng);
            issue_burst(id_t'(stim_rng[23:20]), addr_t'(stim_rng & 32'h0001_fffc),
                        len_t'(stim_rng[31:24] % max_beats));
        end
        wait_drain();
    endtask

    // Upstream R ready, random under back-pressure
    always @(posedge clk) begin
        #1;
        ready_rng = xorshift(ready_rng);
        s_rready  = throttle ? ready_rng[0] : 1'b1;
    end

    // Scoreboard and compare
    always @(posedge clk) begin
        if (!rst) begin
            if (s_arvalid && s_arready) begin
                sb_id.push_back(s_arid);
                sb_addr.push_back(s_araddr);
                sb_len.push_back(s_arlen);
            end
            if (m_arvalid && m_arready) begin
                reserved = reserved + int'(m_arlen) + 1;
            end
            if (s_rvalid && s_rready) begin
                reserved = reserved - 1;
                beats_seen++;
                if (sb_len.size() == 0) begin
                    errors++;
                    $display("%s: R beat arrived with no burst outstanding", test_name);
                end else begin
                    exp_beat = expected_beat(sb_id[0], sb_addr[0], sb_len[0], sb_beat);
                    check_id(exp_beat.id, s_rid);
                    check_data(exp_beat.data, s_rdata);
                    check_resp(exp_beat.resp, exp_beat.last, s_rresp, s_rlast);
                    if (sb_beat == 32'(sb_len[0])) begin
                        void'(sb_id.pop_front());
                        void'(sb_addr.pop_front());
                        void'(sb_len.pop_front());
                        sb_beat = 0;
                    end else begin
                        sb_beat++;
                    end
                end
            end
            if (space_check && reserved > DEPTH) begin
                errors++;
                $display("%s: %0d beats reserved, more than the FIFO holds", test_name, reserved);
            end
            if (space_check && m_rvalid && !m_rready) begin
                errors++;
                $display("%s: slave stalled by m_rready low", test_name);
            end
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Timeout in %s after %0d cycles, %0d bursts still open",
                 test_name, WDOG_CYCLES, sb_len.size());
        $display("Errors: %0d, beats checked: %0d", errors, beats_seen);
        $display("Test failed");
        $finish;
    end

    initial begin
        s_arid      = '0;
        s_araddr    = '0;
        s_arlen     = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b0;
        sb_beat     = 0;
        beats_seen  = 0;
        reserved    = 0;
        errors      = 0;
        stim_rng    = SEED;
        ready_rng   = xorshift(SEED);
        throttle    = 1'b0;
        space_check = 1'b0;

        test_name = "reset_state";
        wait (rst == 1'b0);
        @(negedge clk);
        check_flag("s_arready", 1'b0, s_arready);
        check_flag("m_arvalid", 1'b0, m_arvalid);
        check_flag("s_rvalid", 1'b0, s_rvalid);
        check_flag("m_rready", 1'b1, m_rready);
        @(posedge clk);
        #1;

        // One burst at a time, drained before the next
        for (int i = 0; i < 8; i++) begin
            run_random_bursts("single_bursts", 1, 16);
        end

        throttle = 1'b1;
        run_random_bursts("back_pressure", 12, 16);

        space_check = 1'b1;
        run_random_bursts("space_reservation", 16, 16);
        space_check = 1'b0;
        throttle    = 1'b0;

        // Longer than the FIFO, allowed because nothing is outstanding
        test_name = "oversize_burst";
        issue_burst(4'h9, 32'h0000_3000, 8'd23);
        wait_drain();
        if (reserved != 0) begin
            errors++;
            $display("%s: %0d beats still reserved after the burst drained",
                     test_name, reserved);
        end

        test_name = "resp_passthrough";
        issue_burst(4'h3, 32'h0000_1000, 8'd3);
        issue_burst(4'h4, 32'h0000_2000, 8'd3);
        issue_burst(4'h5, 32'h0001_f000, 8'd7);
        issue_burst(4'h6, 32'h0000_0040, 8'd0);
        wait_drain();

        repeat (4) @(posedge clk);
        $display("Errors: %0d, beats checked: %0d", errors, beats_seen);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/axi_rd_slave_model.sv
//********************
// Behavioral AXI read slave
// Returns queued bursts in order, data derived from the
// address, with random idle cycles between beats
//********************

`timescale 1ns/1ps

module axi_rd_slave_model
    import axi_rd_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic  clk,
    input  logic  rst,
    input  id_t   arid,
    input  addr_t araddr,
    input  len_t  arlen,
    input  logic  arvalid,
    output logic  arready,
    output id_t   rid,
    output data_t rdata,
    output resp_t rresp,
    output logic  rlast,
    output logic  rvalid,
    input  logic  rready
);

    id_t         id_q[$];
    addr_t       addr_q[$];
    len_t        len_q[$];
    int unsigned beat;
    logic [31:0] rng;
    logic        taken;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        rresp   = RESP_OKAY;
        rlast   = 1'b0;
        beat    = 0;
        rng     = SEED;
        forever begin
            @(posedge clk);
            // Handshakes seen at the edge
            if (!rst && arvalid && arready) begin
                id_q.push_back(arid);
                addr_q.push_back(araddr);
                len_q.push_back(arlen);
            end
            taken = !rst && rvalid && rready;
            if (taken) begin
                if (rlast) begin
                    void'(id_q.pop_front());
                    void'(addr_q.pop_front());
                    void'(len_q.pop_front());
                    beat = 0;
                end else begin
                    beat = beat + 1;
                end
            end
            #1;
            rng     = xorshift(rng);
            arready = !rst;
            if (rst) begin
                rvalid = 1'b0;
            end else if (rvalid && !taken) begin
                // Beat still waiting, hold it
                rvalid = 1'b1;
            end else if (id_q.size() != 0 && rng[1:0] != 2'b00) begin
                rvalid = 1'b1;
                rid    = id_q[0];
                rdata  = addr_q[0] + data_t'(4 * beat);
                rresp  = addr_q[0][12] ? RESP_SLVERR : RESP_OKAY;
                rlast  = (beat == 32'(len_q[0]));
            end else begin
                rvalid = 1'b0;
            end
        end
    end

endmodule

// File: tb/tb_clk_gen.sv
//********************
// Testbench clock and reset
// Free-running clock, reset held for a fixed cycle count
//********************

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release lands 1 ns after an edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: verilog/axi_fifo_rd.sv
//********************
// AXI4 read-path decoupling buffer
// Gates read addresses on FIFO space and buffers the
// returned data so the slave is never stalled
//********************

`timescale 1ns/1ps

module axi_fifo_rd
    import axi_rd_pkg::*;
#(
    parameter int FIFO_DEPTH = 32
) (
    input  logic  clk,
    input  logic  rst,

    // Upstream, towards the read master
    input  id_t   s_arid,
    input  addr_t s_araddr,
    input  len_t  s_arlen,
    input  logic  s_arvalid,
    output logic  s_arready,
    output id_t   s_rid,
    output data_t s_rdata,
    output resp_t s_rresp,
    output logic  s_rlast,
    output logic  s_rvalid,
    input  logic  s_rready,

    // Downstream, towards the read slave
    output id_t   m_arid,
    output addr_t m_araddr,
    output len_t  m_arlen,
    output logic  m_arvalid,
    input  logic  m_arready,
    input  id_t   m_rid,
    input  data_t m_rdata,
    input  resp_t m_rresp,
    input  logic  m_rlast,
    input  logic  m_rvalid,
    output logic  m_rready
);

    axi_ar_if ar_up ();
    axi_ar_if ar_dn ();
    axi_r_if  r_up ();
    axi_r_if  r_dn ();

    assign ar_up.id    = s_arid;
    assign ar_up.addr  = s_araddr;
    assign ar_up.len   = s_arlen;
    assign ar_up.valid = s_arvalid;
    assign s_arready   = ar_up.ready;

    assign m_arid      = ar_dn.id;
    assign m_araddr    = ar_dn.addr;
    assign m_arlen     = ar_dn.len;
    assign m_arvalid   = ar_dn.valid;
    assign ar_dn.ready = m_arready;

    assign r_dn.id     = m_rid;
    assign r_dn.data   = m_rdata;
    assign r_dn.resp   = m_rresp;
    assign r_dn.last   = m_rlast;
    assign r_dn.valid  = m_rvalid;
    assign m_rready    = r_dn.ready;

    assign s_rid       = r_up.id;
    assign s_rdata     = r_up.data;
    assign s_rresp     = r_up.resp;
    assign s_rlast     = r_up.last;
    assign s_rvalid    = r_up.valid;
    assign r_up.ready  = s_rready;

    // Reservations retire on upstream beats
    ar_space_gate #(.FIFO_DEPTH(FIFO_DEPTH)) i_ar_space_gate (
        .clk   (clk),
        .rst   (rst),
        .s_ar  (ar_up),
        .m_ar  (ar_dn),
        .r_mon (r_up)
    );

    r_data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_r_data_fifo (
        .clk (clk),
        .rst (rst),
        .m_r (r_dn),
        .s_r (r_up)
    );

endmodule

// File: verilog/r_data_fifo.sv
//********************
// Read-data FIFO
// Buffers R beats from the slave, registered memory read
// followed by an output register for full throughput
//********************

`timescale 1ns/1ps

module r_data_fifo
    import axi_rd_pkg::*;
#(
    parameter int FIFO_DEPTH = 32
) (
    input  logic     clk,
    input  logic     rst,
    axi_r_if.sink    m_r,
    axi_r_if.source  s_r
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;
    localparam int WORD_W = ID_WIDTH + DATA_WIDTH + $bits(resp_t) + 1;

    logic [WORD_W-1:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [WORD_W-1:0] in_word;
    logic [WORD_W-1:0] mem_rd_q;
    logic              mem_valid_q;
    logic [WORD_W-1:0] out_q;
    logic              out_valid_q;
    logic              full;
    logic              empty;
    logic              do_write;
    logic              do_read;
    logic              store_out;

    assign in_word = {m_r.id, m_r.data, m_r.resp, m_r.last};

    // Extra pointer bit separates full from empty
    assign full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W])
                && (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);

    assign m_r.ready = !full;
    assign do_write  = m_r.valid && !full;

    // Output register takes a new beat when empty or being drained
    assign store_out = s_r.ready || !out_valid_q;
    assign do_read   = !empty && (store_out || !mem_valid_q);

    // Write side
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
        end else if (do_write) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= in_word;
        end
    end

    // Memory read stage
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr_q    <= '0;
            mem_valid_q <= 1'b0;
        end else begin
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (store_out || !mem_valid_q) begin
                mem_valid_q <= !empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_read) begin
            mem_rd_q <= mem[rd_ptr_q[ADDR_W-1:0]];
        end
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (store_out) begin
            out_valid_q <= mem_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            out_q <= mem_rd_q;
        end
    end

    assign s_r.valid = out_valid_q;
    assign {s_r.id, s_r.data, s_r.resp, s_r.last} = out_q;

    // Occupancy between the pointers never passes the depth
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        PTR_W'(wr_ptr_q - rd_ptr_q) <= PTR_W'(FIFO_DEPTH));

    a_rvalid_stable: assert property (@(posedge clk) disable iff (rst)
        s_r.valid && !s_r.ready |=> s_r.valid && $stable(s_r.data)
            && $stable(s_r.id) && $stable(s_r.resp) && $stable(s_r.last));

endmodule

// File: verilog/ar_space_gate.sv
//********************
// Read-address space gate
// Holds each AR until its whole burst fits in the data FIFO,
// counts reserved beats and retires one per upstream R beat
//********************

`timescale 1ns/1ps

module ar_space_gate
    import axi_rd_pkg::*;
#(
    parameter int FIFO_DEPTH = 32
) (
    input  logic     clk,
    input  logic     rst,
    axi_ar_if.sink   s_ar,
    axi_ar_if.source m_ar,
    axi_r_if.monitor r_mon
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;
    // Wide enough for counter plus a 256-beat burst
    localparam int SUM_W  = (CNT_W > 9 ? CNT_W : 9) + 1;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t           state_q, state_d;
    logic [CNT_W-1:0] cnt_q, cnt_d;
    id_t              id_q, id_d;
    addr_t            addr_q, addr_d;
    len_t             len_q, len_d;
    logic             arvalid_q, arvalid_d;
    logic             arready_q, arready_d;
    len_t             cand_len;
    logic [SUM_W-1:0] cand_sum;
    logic             fits;
    logic             release_burst;
    logic             beat_out;

    assign s_ar.ready = arready_q;
    assign m_ar.valid = arvalid_q;
    assign m_ar.id    = id_q;
    assign m_ar.addr  = addr_q;
    assign m_ar.len   = len_q;

    assign beat_out = r_mon.valid && r_mon.ready;

    // Burst under test is the incoming one in idle, the held one in wait
    assign cand_len = (state_q == ST_WAIT) ? len_q : s_ar.len;
    assign cand_sum = SUM_W'(cnt_q) + SUM_W'(cand_len) + SUM_W'(1);
    // Nothing outstanding lets an oversize burst through
    assign fits     = (cnt_q == '0) || (cand_sum <= SUM_W'(FIFO_DEPTH));

    always_comb begin
        state_d       = state_q;
        arvalid_d     = arvalid_q && !m_ar.ready;
        arready_d     = arready_q;
        id_d          = id_q;
        addr_d        = addr_q;
        len_d         = len_q;
        release_burst = 1'b0;

        case (state_q)
            ST_IDLE: begin
                arready_d = !arvalid_q || m_ar.ready;
                if (s_ar.valid && arready_q) begin
                    id_d      = s_ar.id;
                    addr_d    = s_ar.addr;
                    len_d     = s_ar.len;
                    arready_d = 1'b0;
                    if (fits) begin
                        release_burst = 1'b1;
                        arvalid_d     = 1'b1;
                    end else begin
                        state_d = ST_WAIT;
                    end
                end
            end
            ST_WAIT: begin
                arready_d = 1'b0;
                if (fits) begin
                    release_burst = 1'b1;
                    arvalid_d     = 1'b1;
                    state_d       = ST_IDLE;
                end
            end
        endcase

        cnt_d = cnt_q;
        if (release_burst) begin
            cnt_d = CNT_W'(cand_sum);
        end
        if (beat_out) begin
            cnt_d = cnt_d - CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            arvalid_q <= 1'b0;
            arready_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            cnt_q     <= cnt_d;
            arvalid_q <= arvalid_d;
            arready_q <= arready_d;
        end
    end

    always_ff @(posedge clk) begin
        id_q   <= id_d;
        addr_q <= addr_d;
        len_q  <= len_d;
    end

    // Every upstream beat must have been reserved by an earlier release
    a_cnt_no_underflow: assert property (@(posedge clk) disable iff (rst)
        beat_out |-> cnt_q != '0);

    a_arvalid_stable: assert property (@(posedge clk) disable iff (rst)
        m_ar.valid && !m_ar.ready |=> m_ar.valid && $stable(m_ar.id)
            && $stable(m_ar.addr) && $stable(m_ar.len));

endmodule

// File: verilog/axi_r_if.sv
//********************
// AXI read-data channel
// One beat per valid/ready handshake
//********************

`timescale 1ns/1ps

interface axi_r_if import axi_rd_pkg::*; ();

    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
    logic  valid;
    logic  ready;

    modport source  (output id, data, resp, last, valid, input ready);
    modport sink    (input id, data, resp, last, valid, output ready);
    modport monitor (input id, data, resp, last, valid, ready);

endinterface

// File: verilog/axi_ar_if.sv
//********************
// AXI read-address channel
// INCR bursts at full width, so no size or burst fields
//********************

`timescale 1ns/1ps

interface axi_ar_if import axi_rd_pkg::*; ();

    id_t   id;
    addr_t addr;
    len_t  len;
    logic  valid;
    logic  ready;

    modport source  (output id, addr, len, valid, input ready);
    modport sink    (input id, addr, len, valid, output ready);
    modport monitor (input id, addr, len, valid, ready);

endinterface

// File: verilog/axi_rd_pkg.sv
//********************
// AXI read path package
// Bus widths, vector types and response codes shared by the
// read-path decoupling buffer
//********************

package axi_rd_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;

    // Byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One data beat at full bus width
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Transaction ID
    typedef logic [ID_WIDTH-1:0] id_t;

    // Burst length, beats minus one
    typedef logic [7:0] len_t;

    // Read response
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage
